// File: design/backup_cfg_pkg.sv
`default_nettype none

package backup_cfg_pkg;

	// ==============================
	// Widths
	// ==============================
	localparam int BUF_AW    = 8;   // 256 words per 512-byte sector
	localparam int WORD_W    = 16;  // SD buffer and memory word
	localparam int LBA_W     = 9;   // Sector index into the save image
	localparam int SAVE_SZ_W = 9;   // Last sector index of the save

	typedef logic [LBA_W-1:0]     lba_t;
	typedef logic [WORD_W-1:0]    word_t;
	typedef logic [BUF_AW-1:0]    buf_addr_t;
	typedef logic [SAVE_SZ_W-1:0] save_sz_t;

	// ==============================
	// Sector counts
	// ==============================
	// A load always pulls the largest image the core can use
	localparam lba_t LOAD_LAST_SECTOR = 9'd256;

	// Masks ORed into the save size, one per save type
	localparam save_sz_t MASK_EEPROM = 9'h00F;  // 8 KB
	localparam save_sz_t MASK_SRAM   = 9'h03F;  // 32 KB
	localparam save_sz_t MASK_FLASH  = 9'h07F;  // 64 KB, bit 7 added for 1M parts

endpackage

`default_nettype wire

// File: design/backup_types_pkg.sv
`default_nettype none

package backup_types_pkg;

	// Sequencer states, loads run READ/WAIT/XFER and saves XFER/WRITE/WAIT
	typedef enum logic [2:0] {
		IDLE,
		LD_READ,
		LD_WAIT,
		LD_XFER,
		SV_XFER,
		SV_WRITE,
		SV_WAIT
	} seq_state_t;

	// One buffer word per ISSUE/AWAIT pair
	typedef enum logic {
		ISSUE,
		AWAIT
	} xfer_step_t;

endpackage

`default_nettype wire

// File: design/buf_port_if.sv
`default_nettype none

// Memory-side port of the sector buffer
interface buf_port_if import backup_cfg_pkg::*; #(
	parameter int AW = BUF_AW
);
	logic [AW-1:0] addr;   // Word address inside the sector
	logic          we;     // Write strobe, one word per clock
	word_t         wdata;  // Word from the memory channel
	word_t         rdata;  // Registered read, one clock behind addr

	// Transfer engine side
	modport xfer (output addr, output we, output wdata, input rdata);

	// RAM side
	modport ram (input addr, input we, input wdata, output rdata);

endinterface

`default_nettype wire

// File: design/save_size_tracker.sv
`default_nettype none

module save_size_tracker import backup_cfg_pkg::*; (
	input  wire      clk_sys,
	input  wire      reset,
	input  wire      cart_start,   // New cartridge, forget old size
	input  wire      bus_req,      // Core bus access strobe
	input  wire      save_eeprom,
	input  wire      save_sram,
	input  wire      save_flash,
	input  wire      flash_1m,     // 128 KB flash part
	input  wire      busy,         // Sequencer running
	output save_sz_t save_sz,
	output logic     bk_ena,
	output logic     pending
);

	save_sz_t size_or;   // Masks of all strobes seen this cycle
	logic     bk_write;  // Core wrote to its save memory

	// Flash grows to 256 sectors when the 1M flag is set
	always_comb begin
		size_or = '0;
		if (save_eeprom) size_or = size_or | MASK_EEPROM;
		if (save_sram)   size_or = size_or | MASK_SRAM;
		if (save_flash)  size_or = size_or | {1'b0, flash_1m, MASK_FLASH[6:0]};
	end

	assign bk_write = bus_req && (save_eeprom || save_sram || save_flash);

	// ==============================
	// Size and pending flag
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			save_sz <= '0;
			bk_ena  <= 1'b0;
			pending <= 1'b0;
		end else begin
			if (cart_start)
				save_sz <= '0;                  // Size only ever grows until next cart
			else if (bus_req)
				save_sz <= save_sz | size_or;

			bk_ena <= |save_sz;                // Nothing to move while size is zero

			if (bk_write)  pending <= 1'b1;    // Dirty until a transfer runs
			else if (busy) pending <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: design/backup_sequencer.sv
`default_nettype none

module backup_sequencer
	import backup_cfg_pkg::*;
	import backup_types_pkg::*;
#(
	parameter lba_t LAST_LOAD = LOAD_LAST_SECTOR
) (
	input  wire      clk_sys,
	input  wire      reset,
	input  wire      bk_load,      // Level requests from the menu
	input  wire      bk_save,
	input  wire      bk_autosave,
	input  wire      bk_ena,
	input  wire      pending,
	input  save_sz_t save_sz,
	input  wire      sd_ack,
	output lba_t     sd_lba,
	output logic     sd_rd,
	output logic     sd_wr,
	output logic     bk_busy,
	output logic     xfer_start,
	output logic     xfer_load,    // 1 = buffer to memory
	input  wire      xfer_done
);

	seq_state_t state;
	logic       old_load, old_save, old_auto, old_ack;
	logic       load_rise, save_rise, auto_rise;
	logic       ack_fall;

	assign load_rise = bk_load & ~old_load;
	assign save_rise = bk_save & ~old_save;
	assign auto_rise = bk_autosave & ~old_auto & pending;  // Only a dirty save autosaves
	assign ack_fall  = old_ack & ~sd_ack;                  // SD host finished the sector

	assign bk_busy = (state != IDLE);

	// ==============================
	// Sector sequencing
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= IDLE;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			xfer_start <= 1'b0;
			xfer_load  <= 1'b0;
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_auto   <= 1'b0;
			old_ack    <= 1'b0;
		end else begin
			old_load <= bk_load;
			old_save <= bk_save;
			old_auto <= bk_autosave;
			old_ack  <= sd_ack;

			// Requests drop once the host takes them
			if (~old_ack & sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				IDLE: begin
					sd_lba <= '0;
					if (bk_ena && (load_rise || save_rise || auto_rise)) begin
						xfer_load <= load_rise;  // Load wins over a save in the same cycle
						if (load_rise) begin
							state <= LD_READ;
						end else begin
							xfer_start <= 1'b1;  // Save fills the buffer first
							state      <= SV_XFER;
						end
					end
				end

				// Load: SD into buffer, then buffer into memory
				LD_READ: begin
					sd_rd <= 1'b1;
					state <= LD_WAIT;
				end
				LD_WAIT: if (ack_fall) begin
					xfer_start <= 1'b1;
					state      <= LD_XFER;
				end
				LD_XFER: if (xfer_done) begin
					xfer_start <= 1'b0;
					sd_lba     <= sd_lba + 1'b1;
					state      <= (sd_lba == LAST_LOAD) ? IDLE : LD_READ;
				end

				// Save: memory into buffer, then buffer out to SD
				SV_XFER: if (xfer_done) begin
					xfer_start <= 1'b0;
					state      <= SV_WRITE;
				end
				SV_WRITE: begin
					sd_wr <= 1'b1;
					state <= SV_WAIT;
				end
				SV_WAIT: if (ack_fall) begin
					sd_lba <= sd_lba + 1'b1;
					if (sd_lba == save_sz) begin
						state <= IDLE;       // Last sector of the save written
					end else begin
						xfer_start <= 1'b1;
						state      <= SV_XFER;
					end
				end

				default: state <= IDLE;
			endcase
		end
	end

	// ==============================
	// Checks
	// ==============================
	a_sd_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr));

	// Buffer belongs to the SD host while it acknowledges
	a_xfer_after_ack: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(xfer_start) |-> !sd_ack);

endmodule

`default_nettype wire

// File: design/sector_transfer.sv
`default_nettype none

module sector_transfer
	import backup_cfg_pkg::*;
	import backup_types_pkg::*;
#(
	parameter int AW = BUF_AW
) (
	input  wire             clk_sys,
	input  wire             reset,
	input  wire             xfer_start,
	input  wire             xfer_load,
	input  lba_t            sd_lba,
	output logic            xfer_done,
	output logic [AW+7:0]   mem_addr,
	output word_t           mem_din,
	output logic            mem_req,
	output logic            mem_rnw,
	input  word_t           mem_dout,
	input  wire             mem_ready,
	buf_port_if.xfer        bport
);

	xfer_step_t    step;
	logic [AW-1:0] cnt;   // Word inside the sector

	assign mem_addr = {sd_lba[7:0], cnt};
	assign mem_rnw  = ~xfer_load;            // Load writes memory, save reads it
	assign mem_din  = bport.rdata;           // Valid from the first AWAIT cycle

	assign bport.addr  = cnt;
	assign bport.wdata = mem_dout;
	assign bport.we    = (step == AWAIT) && mem_ready && !xfer_load;

	// ==============================
	// Word walk
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset || !xfer_start) begin
			cnt       <= '0;
			step      <= ISSUE;
			mem_req   <= 1'b0;
			xfer_done <= 1'b0;
		end else begin
			mem_req <= 1'b0;                   // Single-cycle request
			case (step)
				ISSUE: if (!xfer_done) begin
					mem_req <= 1'b1;
					step    <= AWAIT;
				end
				AWAIT: if (mem_ready) begin
					step <= ISSUE;
					if (&cnt) xfer_done <= 1'b1;  // Word 255 finished
					else      cnt       <= cnt + 1'b1;
				end
				default: step <= ISSUE;
			endcase
		end
	end

	// One word in flight at a time on the memory channel
	a_one_outstanding: assert property (@(posedge clk_sys) disable iff (reset)
		mem_req |=> !mem_req until_with mem_ready);

endmodule

`default_nettype wire

// File: design/sector_buffer.sv
`default_nettype none

module sector_buffer import backup_cfg_pkg::*; #(
	parameter int AW = BUF_AW
) (
	input  wire           clk_sys,
	buf_port_if.ram       mport,
	input  wire  [AW-1:0] sd_buff_addr,
	input  word_t         sd_buff_dout,
	input  wire           sd_buff_wr,
	output word_t         sd_buff_din
);

	word_t mem [0:(2**AW)-1];   // One 512-byte sector

	// ==============================
	// Memory side
	// ==============================
	always @(posedge clk_sys) begin
		if (mport.we)
			mem[mport.addr] <= mport.wdata;
		mport.rdata <= mem[mport.addr];      // Old data on a same-address write
	end

	// ==============================
	// SD side
	// ==============================
	always @(posedge clk_sys) begin
		if (sd_buff_wr)
			mem[sd_buff_addr] <= sd_buff_dout;
		sd_buff_din <= mem[sd_buff_addr];
	end

endmodule

`default_nettype wire

// File: design/backup_ctrl_top.sv
`default_nettype none

module backup_ctrl_top import backup_cfg_pkg::*; (
	input  wire              clk_sys,
	input  wire              reset,
	// SD host
	output lba_t             sd_lba,
	output logic             sd_rd,
	output logic             sd_wr,
	input  wire              sd_ack,
	input  buf_addr_t        sd_buff_addr,
	input  word_t            sd_buff_dout,
	output word_t            sd_buff_din,
	input  wire              sd_buff_wr,
	// Memory channel
	output logic [BUF_AW+7:0] mem_addr,
	output word_t            mem_din,
	input  word_t            mem_dout,
	output logic             mem_req,
	output logic             mem_rnw,
	input  wire              mem_ready,
	// Core
	input  wire              bus_req,
	input  wire              save_eeprom,
	input  wire              save_sram,
	input  wire              save_flash,
	input  wire              flash_1m,
	input  wire              cart_start,
	// Requests and status
	input  wire              bk_load,
	input  wire              bk_save,
	input  wire              bk_autosave,
	output logic             bk_busy
);

	save_sz_t save_sz;
	logic     bk_ena, pending;
	logic     xfer_start, xfer_load, xfer_done;

	buf_port_if #(.AW(BUF_AW)) bport_i ();

	save_size_tracker size_i (
		.clk_sys, .reset, .cart_start, .bus_req,
		.save_eeprom, .save_sram, .save_flash, .flash_1m,
		.busy(bk_busy), .save_sz, .bk_ena, .pending
	);

	backup_sequencer #(.LAST_LOAD(LOAD_LAST_SECTOR)) seq_i (
		.clk_sys, .reset, .bk_load, .bk_save, .bk_autosave,
		.bk_ena, .pending, .save_sz, .sd_ack, .sd_lba, .sd_rd, .sd_wr,
		.bk_busy, .xfer_start, .xfer_load, .xfer_done
	);

	sector_transfer #(.AW(BUF_AW)) xfer_i (
		.clk_sys, .reset, .xfer_start, .xfer_load, .sd_lba, .xfer_done,
		.mem_addr, .mem_din, .mem_req, .mem_rnw, .mem_dout, .mem_ready,
		.bport(bport_i.xfer)
	);

	sector_buffer #(.AW(BUF_AW)) buf_i (
		.clk_sys, .mport(bport_i.ram),
		.sd_buff_addr, .sd_buff_dout, .sd_buff_wr, .sd_buff_din
	);

endmodule

`default_nettype wire

// File: tb/tb_models.sv
`default_nettype none

// SD host: fills the buffer on a read, walks it back out on a write
module sd_host_model import backup_cfg_pkg::*; (
	input  wire       clk_sys,
	input  wire [1:0] ack_wait,      // Extra card latency for the next sector
	input  lba_t      sd_lba,
	input  wire       sd_rd,
	input  wire       sd_wr,
	output logic      sd_ack,
	output buf_addr_t sd_buff_addr,
	output word_t     sd_buff_dout,
	output logic      sd_buff_wr,
	output logic      chk_valid,     // sd_buff_din now holds word chk_addr
	output buf_addr_t chk_addr
);

	// Image word, unique per sector and word
	function automatic word_t image_word(input lba_t lba, input buf_addr_t a);
		return {lba[7:0], a} ^ {lba[8], 15'h2D3C};
	endfunction

	initial begin
		lba_t lba;
		logic is_read;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		chk_valid    = 1'b0;
		chk_addr     = '0;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				lba     = sd_lba;
				is_read = sd_rd;
				repeat (1 + ack_wait) @(negedge clk_sys);  // Card latency
				sd_ack = 1'b1;
				if (is_read) begin
					for (int i = 0; i < 256; i++) begin
						sd_buff_addr = buf_addr_t'(i);
						sd_buff_dout = image_word(lba, buf_addr_t'(i));
						sd_buff_wr   = 1'b1;
						@(negedge clk_sys);
					end
					sd_buff_wr = 1'b0;
				end else begin
					// Read port lags one clock, so the flag trails the address
					for (int i = 0; i <= 256; i++) begin
						if (i < 256) sd_buff_addr = buf_addr_t'(i);
						chk_valid = (i > 0);
						chk_addr  = buf_addr_t'(i - 1);
						@(negedge clk_sys);
					end
					chk_valid = 1'b0;
				end
				sd_ack = 1'b0;                 // Sector complete
			end
		end
	end

endmodule

// Backup memory: answers each request after a random delay
module backup_mem_model import backup_cfg_pkg::*; (
	input  wire              clk_sys,
	input  wire [1:0]        mem_wait,   // Extra latency for the next word
	input  wire [BUF_AW+7:0] mem_addr,
	input  wire              mem_req,
	output word_t            mem_dout,
	output logic             mem_ready
);

	// Save data as a fixed function of the address
	function automatic word_t backup_word(input logic [BUF_AW+7:0] a);
		return {a[7:0], a[15:8]} ^ 16'hC3A5;
	endfunction

	initial begin
		logic [BUF_AW+7:0] addr;
		mem_dout  = '0;
		mem_ready = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (mem_req) begin
				addr = mem_addr;
				repeat (1 + mem_wait) @(negedge clk_sys);  // 0 to 3 extra cycles
				mem_dout  = backup_word(addr);
				mem_ready = 1'b1;
				@(negedge clk_sys);
				mem_ready = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_backup_ctrl.sv
`default_nettype none

module tb_backup_ctrl
	import backup_cfg_pkg::*;
();

	// All sectors moved below at 6 cycles per word, plus SD turnaround per sector
	localparam int SECTORS    = 64 + 257 + 64 + 256;
	localparam int MAX_CYCLES = SECTORS * (256 * 6 + 300) + 2000;

	logic              clk_sys, reset;
	lba_t              sd_lba;
	logic              sd_rd, sd_wr, sd_ack, sd_buff_wr, chk_valid;
	buf_addr_t         sd_buff_addr, chk_addr;
	word_t             sd_buff_dout, sd_buff_din, mem_din, mem_dout;
	logic [BUF_AW+7:0] mem_addr;
	logic              mem_req, mem_rnw, mem_ready;
	logic              bus_req, save_eeprom, save_sram, save_flash, flash_1m, cart_start;
	logic              bk_load, bk_save, bk_autosave, bk_busy;
	logic              rd_q = 1'b0, wr_q = 1'b0;
	logic              idle_watch = 1'b0;  // bk_busy must stay low while set
	logic              load_run = 1'b0;    // A load request is being served
	logic [1:0]        mem_wait = 2'd0, ack_wait = 2'd0;  // Random model latencies
	int                cycles = 0, rd_total = 0, wr_total = 0;
	int                sect_cnt = 0;       // Index due on the next SD request

	backup_ctrl_top  dut0 (.*);
	sd_host_model    sd0 (.*);
	backup_mem_model mem0 (.*);

	function automatic word_t image_word(input lba_t lba, input buf_addr_t a);
		return {lba[7:0], a} ^ {lba[8], 15'h2D3C};
	endfunction

	function automatic word_t backup_word(input logic [BUF_AW+7:0] a);
		return {a[7:0], a[15:8]} ^ 16'hC3A5;
	endfunction

	task automatic report_failure(input string what);
		$display("TB FAILED");
		$display("%s", what);
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		report_failure($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic expect_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp) else report_mismatch(name, got, exp);
	endtask

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ==============================
	// Sector bookkeeping and timeout
	// ==============================
	always @(posedge clk_sys) begin
		rd_q <= sd_rd;
		wr_q <= sd_wr;
		if (!bk_busy) sect_cnt <= 0;
		else if ((sd_rd && !rd_q) || (sd_wr && !wr_q)) sect_cnt <= sect_cnt + 1;
		if (sd_rd && !rd_q) rd_total <= rd_total + 1;
		if (sd_wr && !wr_q) wr_total <= wr_total + 1;
		cycles <= cycles + 1;
		if (cycles > MAX_CYCLES) report_failure("timeout, run did not finish in time");
	end

	// ==============================
	// Checks
	// ==============================
	a_lba_order: assert property (@(posedge clk_sys) disable iff (reset)
		($rose(sd_rd) || $rose(sd_wr)) |-> sd_lba == sect_cnt[LBA_W-1:0])
		else report_mismatch("sd_lba", $sampled(sd_lba), $sampled(sect_cnt));
	a_rnw_dir: assert property (@(posedge clk_sys) disable iff (reset)
		mem_req |-> mem_rnw == !load_run)
		else report_mismatch("mem_rnw", $sampled(mem_rnw), !$sampled(load_run));
	a_load_data: assert property (@(posedge clk_sys) disable iff (reset)
		(mem_req && load_run) |-> mem_din == image_word(sd_lba, mem_addr[7:0]))
		else report_mismatch("mem_din", $sampled(mem_din),
			image_word($sampled(sd_lba), $sampled(mem_addr[7:0])));
	a_save_data: assert property (@(posedge clk_sys) disable iff (reset)
		chk_valid |-> sd_buff_din == backup_word({sd_lba[7:0], chk_addr}))
		else report_mismatch("sd_buff_din", $sampled(sd_buff_din),
			backup_word({$sampled(sd_lba[7:0]), $sampled(chk_addr)}));
	a_req_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		mem_req |=> !mem_req) else report_failure("mem_req held for two cycles");
	a_req_ready: assert property (@(posedge clk_sys) disable iff (reset)
		mem_req |=> (!mem_req until_with mem_ready))
		else report_failure("second mem_req before mem_ready");
	a_sd_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr)) else report_failure("sd_rd and sd_wr high together");
	a_rd_hold: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(sd_rd) |-> (sd_rd until_with sd_ack)) else report_failure("sd_rd fell before sd_ack");
	a_wr_hold: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(sd_wr) |-> (sd_wr until_with sd_ack)) else report_failure("sd_wr fell before sd_ack");
	a_ignored: assert property (@(posedge clk_sys) disable iff (reset)
		idle_watch |-> !bk_busy) else report_failure("bk_busy rose on a request that must be ignored");

	task automatic write_save_type(input logic eeprom, input logic sram, input logic flash);
		bus_req     = 1'b1;
		save_eeprom = eeprom;
		save_sram   = sram;
		save_flash  = flash;
		@(negedge clk_sys);
		{bus_req, save_eeprom, save_sram, save_flash} = '0;
		repeat (3) @(negedge clk_sys);             // Size, then bk_ena
	endtask

	task automatic pulse_request(input logic load, input logic save, input logic autosave);
		{bk_load, bk_save, bk_autosave} = {load, save, autosave};
		repeat (2) @(negedge clk_sys);
		{bk_load, bk_save, bk_autosave} = '0;
	endtask

	task automatic run_to_idle();
		while (!bk_busy) @(negedge clk_sys);
		while (bk_busy) @(negedge clk_sys);
	endtask

	task automatic expect_ignored(input logic load, input logic save, input logic autosave);
		idle_watch = 1'b1;
		pulse_request(load, save, autosave);
		repeat (20) @(negedge clk_sys);
		idle_watch = 1'b0;
	endtask

	// ==============================
	// Stimulus
	// ==============================
	initial begin
		int base;
		void'($urandom(91));
		// New latencies every clock, read by the models at the falling edge
		fork
			forever begin
				@(posedge clk_sys);
				mem_wait = 2'($urandom % 4);
				ack_wait = 2'($urandom % 4);
			end
		join_none
		reset = 1'b1;
		{bus_req, save_eeprom, save_sram, save_flash, flash_1m, cart_start} = '0;
		{bk_load, bk_save, bk_autosave} = '0;
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		expect_value("sd_rd", sd_rd, 0);
		expect_value("sd_wr", sd_wr, 0);
		expect_value("mem_req", mem_req, 0);
		expect_value("bk_busy", bk_busy, 0);
		expect_ignored(0, 1, 0);                   // No size yet
		expect_ignored(0, 0, 1);

		write_save_type(0, 1, 0);                  // SRAM, 64 sectors
		base = wr_total;
		pulse_request(0, 1, 0);
		run_to_idle();
		expect_value("sd_wr rises", wr_total - base, 64);

		base = rd_total;
		load_run = 1'b1;
		pulse_request(1, 0, 0);
		run_to_idle();
		load_run = 1'b0;
		expect_value("sd_rd rises", rd_total - base, 257);

		expect_ignored(0, 0, 1);                   // Pending cleared by the last run
		write_save_type(1, 0, 0);
		base = wr_total;
		pulse_request(0, 0, 1);
		run_to_idle();
		expect_value("sd_wr rises", wr_total - base, 64);

		flash_1m = 1'b1;                           // 1M flash, 256 sectors
		write_save_type(0, 0, 1);
		base = wr_total;
		pulse_request(0, 1, 0);
		run_to_idle();
		expect_value("sd_wr rises", wr_total - base, 256);
		cart_start = 1'b1;
		@(negedge clk_sys);
		cart_start = 1'b0;
		repeat (3) @(negedge clk_sys);
		expect_ignored(0, 1, 0);

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: backup_ctrl_top.f
design/backup_cfg_pkg.sv
design/backup_types_pkg.sv
design/buf_port_if.sv
design/save_size_tracker.sv
design/backup_sequencer.sv
design/sector_transfer.sv
design/sector_buffer.sv
design/backup_ctrl_top.sv
tb/tb_models.sv
tb/tb_backup_ctrl.sv
